// ==== lc3b_fetch.f ====
logic/lc3b_pkg.sv
logic/pc_select.sv
logic/instr_reg.sv
logic/if_datapath.sv
logic/imem_port.sv
logic/lc3b_fetch_top.sv
verification/tb_clock.sv
verification/tb_lc3b_fetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_lc3b_fetch
FILELIST  ?= lc3b_fetch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Test failed"; exit 1; \
	elif ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Test ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_lc3b_fetch.sv ====
`timescale 1ns/1ps

module tb_lc3b_fetch;

    import lc3b_pkg::*;

    localparam int MEM_WORDS   = 256;
    localparam int MEM_LATENCY = 2;
    localparam int WAIT_LIMIT  = 200;  // Cycles any wait loop may take

    logic     clk;
    logic     reset_init;
    logic     hold_reset;
    logic     if_stall_count_reset;
    logic     stall;
    logic     flush;
    logic     br_en;
    logic     trap_en;
    logic     jmp_jsr_en;
    logic     b11;
    lc3b_word pc_br_in;
    lc3b_word sr1_data_in;
    lc3b_word trap_mem;
    logic     mem_wr_en;
    lc3b_word mem_wr_addr;
    lc3b_word mem_wr_data;
    lc3b_word pc_out;
    lc3b_word instruction;
    logic     instr_valid;
    lc3b_reg  src1;
    lc3b_reg  src2;
    lc3b_reg  dest;
    lc3b_word if_stall_count;

    lc3b_word    exp_mem [MEM_WORDS];
    logic [15:0] lfsr_state;

    // Reference state of the fetch stage and of the memory wait
    lc3b_word m_pc;
    lc3b_word m_ir;
    lc3b_word m_count;
    lc3b_word m_last;
    logic     m_valid;
    int       m_wait;
    logic     m_ready = 1'b0;

    assign if_stall_count_reset = reset_init || hold_reset;

    tb_clock u_clock (.clk(clk), .reset(reset_init));

    lc3b_fetch_top #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) UUT (.*);

    // ==============================
    // Reference functions
    // ==============================

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic lc3b_word random_bits(int count);
        lc3b_word value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsr_bit()};
        end
        return value;
    endfunction

    function automatic lc3b_word expected_word(lc3b_word addr);
        return exp_mem[addr[8:1]];  // Byte address to word index
    endfunction

    function automatic logic [8:0] expected_fields(lc3b_word word);
        return {word[11:9], word[8:6], word[2:0]};
    endfunction

    function automatic lc3b_word expected_target(lc3b_word seq_pc);
        if (br_en) return pc_br_in;
        if (trap_en) return trap_mem;
        if (jmp_jsr_en && b11) return pc_br_in;  // JSR
        if (jmp_jsr_en) return sr1_data_in;
        return seq_pc;
    endfunction

    task automatic stop_with_failure(string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(string name, lc3b_word expected, lc3b_word actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_fetch(string phase);
        int n;
        n = 0;
        while (instr_valid !== 1'b1) begin
            if (n == WAIT_LIMIT) stop_with_failure({"Timeout: nothing fetched during ", phase});
            next_cycle();
            n++;
        end
    endtask

    // ==============================
    // Model and comparison
    // ==============================

    task automatic update_model();
        int   wait_now;
        logic resp;
        logic pc_load;
        logic ir_load;
        if (if_stall_count_reset) begin
            m_pc    = '0;
            m_ir    = '0;
            m_valid = 1'b0;
            m_count = '0;
            m_last  = '0;
            m_wait  = 0;
            m_ready = 1'b1;
        end else if (m_ready) begin
            wait_now = (m_pc != m_last) ? 0 : m_wait;  // New address waits from zero
            resp     = (wait_now == MEM_LATENCY);
            pc_load  = br_en || trap_en || jmp_jsr_en || (resp && !stall);
            ir_load  = pc_load && resp && !stall && !flush;
            if (!m_valid) m_count = m_count + 16'd1;
            if (ir_load) begin
                m_ir    = expected_word(m_pc);
                m_valid = 1'b1;
            end else if (flush || resp) begin
                m_valid = 1'b0;
            end
            m_last = m_pc;
            m_wait = resp ? 0 : wait_now + 1;
            if (pc_load) m_pc = expected_target(m_pc + 16'd2);
        end
    endtask

    task automatic compare_outputs();
        check_value("pc_out", m_pc, pc_out);
        check_value("instruction", m_ir, instruction);
        check_value("instr_valid", 16'(m_valid), 16'(instr_valid));
        check_value("if_stall_count", m_count, if_stall_count);
        check_value("register fields", 16'(expected_fields(m_ir)), 16'({dest, src1, src2}));
    endtask

    always begin
        @(posedge clk);
        update_model();
        @(negedge clk);  // Outputs have settled by the falling edge
        if (m_ready) compare_outputs();
    end

    // ==============================
    // Stimulus
    // ==============================

    initial begin
        int       n;
        lc3b_word target;
        {stall, flush, br_en, trap_en, jmp_jsr_en, b11} = '0;
        pc_br_in    = '0;
        sr1_data_in = '0;
        trap_mem    = '0;
        mem_wr_en   = 1'b0;
        mem_wr_addr = '0;
        mem_wr_data = '0;
        hold_reset  = 1'b1;  // Reset stays on until the program is loaded
        lfsr_state  = 16'd32211;

        for (int k = 0; k < MEM_WORDS; k++) begin
            next_cycle();
            mem_wr_en   = 1'b1;
            mem_wr_addr = 16'(2 * k);
            mem_wr_data = random_bits(16);
            exp_mem[k]  = mem_wr_data;
        end
        next_cycle();
        mem_wr_en  = 1'b0;
        hold_reset = 1'b0;

        // Straight-line fetch
        n = 0;
        while (pc_out != 16'h0040) begin
            if (n == WAIT_LIMIT) stop_with_failure("Timeout: sequential fetch stopped advancing");
            next_cycle();
            n++;
        end

        stall = 1'b1;
        repeat (10) next_cycle();
        stall = 1'b0;

        // Every redirect combination, with and without stall
        for (int i = 1; i < 32; i++) begin
            {stall, br_en, trap_en, jmp_jsr_en, b11} = 5'(i);
            pc_br_in    = {random_bits(15), 1'b0};
            sr1_data_in = {random_bits(15), 1'b0};
            trap_mem    = {random_bits(15), 1'b0};
            target      = expected_target(pc_out + 16'd2);
            next_cycle();
            if (br_en || trap_en || jmp_jsr_en) check_value("redirect target", target, pc_out);
        end
        {stall, br_en, trap_en, jmp_jsr_en, b11} = '0;

        repeat (400) begin
            stall       = (random_bits(2) == 16'd0);
            flush       = (random_bits(3) == 16'd0);
            br_en       = (random_bits(5) == 16'd0);
            trap_en     = (random_bits(5) == 16'd0);
            jmp_jsr_en  = (random_bits(5) == 16'd0);
            b11         = lfsr_bit();
            pc_br_in    = {random_bits(15), 1'b0};
            sr1_data_in = {random_bits(15), 1'b0};
            trap_mem    = {random_bits(15), 1'b0};
            next_cycle();
        end
        {stall, flush, br_en, trap_en, jmp_jsr_en, b11} = '0;

        wait_for_fetch("flush setup");
        stall = 1'b1;
        flush = 1'b1;
        next_cycle();
        check_value("flush clears instr_valid", 16'd0, 16'(instr_valid));
        stall = 1'b0;
        flush = 1'b0;

        hold_reset = 1'b1;
        next_cycle();
        check_value("pc_out after reset", 16'd0, pc_out);
        check_value("if_stall_count after reset", 16'd0, if_stall_count);
        hold_reset = 1'b0;
        wait_for_fetch("restart after reset");
        repeat (5) next_cycle();

        $display("RESULT: PASS");
        $finish;
    end

endmodule : tb_lc3b_fetch

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;  // Released off the edge like the rest of the stimulus
    end

endmodule : tb_clock

// ==== logic/lc3b_fetch_top.sv ====
`timescale 1ns/1ps

module lc3b_fetch_top #(
    parameter int MEM_WORDS   = lc3b_pkg::DEFAULT_MEM_WORDS,
    parameter int MEM_LATENCY = lc3b_pkg::DEFAULT_MEM_LATENCY
) (
    input  logic              clk,
    input  logic              if_stall_count_reset,
    input  logic              stall,
    input  logic              flush,
    input  logic              br_en,
    input  logic              trap_en,
    input  logic              jmp_jsr_en,
    input  logic              b11,
    input  lc3b_pkg::lc3b_word pc_br_in,
    input  lc3b_pkg::lc3b_word sr1_data_in,
    input  lc3b_pkg::lc3b_word trap_mem,
    input  logic              mem_wr_en,
    input  lc3b_pkg::lc3b_word mem_wr_addr,
    input  lc3b_pkg::lc3b_word mem_wr_data,
    output lc3b_pkg::lc3b_word pc_out,
    output lc3b_pkg::lc3b_word instruction,
    output logic              instr_valid,
    output lc3b_pkg::lc3b_reg  src1,
    output lc3b_pkg::lc3b_reg  src2,
    output lc3b_pkg::lc3b_reg  dest,
    output lc3b_pkg::lc3b_word if_stall_count
);

    import lc3b_pkg::*;

    // Memory request between fetch and the instruction memory
    logic     read_a;
    logic     resp_a;
    lc3b_word address_a;
    lc3b_word rdata_a;

    if_datapath u_if_datapath (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .resp_a               (resp_a),
        .stall                (stall),
        .flush                (flush),
        .br_en                (br_en),
        .trap_en              (trap_en),
        .jmp_jsr_en           (jmp_jsr_en),
        .b11                  (b11),
        .rdata_a              (rdata_a),
        .pc_br_in             (pc_br_in),
        .sr1_data_in          (sr1_data_in),
        .trap_mem             (trap_mem),
        .pc_out               (pc_out),
        .instruction          (instruction),
        .if_stall_count       (if_stall_count),
        .address_a            (address_a),
        .read_a               (read_a),
        .instr_valid          (instr_valid),
        .src1                 (src1),
        .src2                 (src2),
        .dest                 (dest)
    );

    imem_port #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_imem_port (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .read_a               (read_a),
        .mem_wr_en            (mem_wr_en),
        .address_a            (address_a),
        .mem_wr_addr          (mem_wr_addr),
        .mem_wr_data          (mem_wr_data),
        .resp_a               (resp_a),
        .rdata_a              (rdata_a)
    );

endmodule : lc3b_fetch_top

// ==== logic/imem_port.sv ====
`timescale 1ns/1ps

module imem_port #(
    parameter int MEM_WORDS   = lc3b_pkg::DEFAULT_MEM_WORDS,
    parameter int MEM_LATENCY = lc3b_pkg::DEFAULT_MEM_LATENCY
) (
    input  logic              clk,
    input  logic              if_stall_count_reset,
    input  logic              read_a,
    input  logic              mem_wr_en,
    input  lc3b_pkg::lc3b_word address_a,
    input  lc3b_pkg::lc3b_word mem_wr_addr,
    input  lc3b_pkg::lc3b_word mem_wr_data,
    output logic              resp_a,
    output lc3b_pkg::lc3b_word rdata_a
);

    import lc3b_pkg::*;

    localparam int ADDR_BITS = $clog2(MEM_WORDS);
    localparam logic [WAIT_BITS-1:0] LATENCY = WAIT_BITS'(MEM_LATENCY);

    lc3b_word             mem [MEM_WORDS];
    lc3b_word             last_addr;
    logic [WAIT_BITS-1:0] wait_count;
    logic [WAIT_BITS-1:0] wait_now;

    // ==============================
    // Storage
    // ==============================

    // Byte addresses come in so bit 0 is dropped
    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem[mem_wr_addr[ADDR_BITS:1]] <= mem_wr_data;
        end
    end

    assign rdata_a = mem[address_a[ADDR_BITS:1]];

    // ==============================
    // Wait state
    // ==============================

    // A new address starts the wait from zero in its first cycle
    assign wait_now = (address_a != last_addr) ? '0 : wait_count;
    assign resp_a   = read_a && (wait_now == LATENCY);

    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            last_addr  <= '0;
            wait_count <= '0;
        end else begin
            last_addr <= address_a;
            if (!read_a || resp_a) begin
                wait_count <= '0;  // Same address waits the full latency again
            end else begin
                wait_count <= wait_now + 1'b1;
            end
        end
    end

    a_resp_is_pulse : assert property (
        @(posedge clk) disable iff (if_stall_count_reset)
        (MEM_LATENCY > 0 && resp_a) |=> !resp_a
    ) else $error("resp_a high in two consecutive cycles");

endmodule : imem_port

// ==== logic/if_datapath.sv ====
`timescale 1ns/1ps

module if_datapath (
    input  logic              clk,
    input  logic              if_stall_count_reset,
    input  logic              resp_a,
    input  logic              stall,
    input  logic              flush,
    input  logic              br_en,
    input  logic              trap_en,
    input  logic              jmp_jsr_en,
    input  logic              b11,
    input  lc3b_pkg::lc3b_word rdata_a,
    input  lc3b_pkg::lc3b_word pc_br_in,
    input  lc3b_pkg::lc3b_word sr1_data_in,
    input  lc3b_pkg::lc3b_word trap_mem,
    output lc3b_pkg::lc3b_word pc_out,
    output lc3b_pkg::lc3b_word instruction,
    output lc3b_pkg::lc3b_word if_stall_count,
    output lc3b_pkg::lc3b_word address_a,
    output logic              read_a,
    output logic              instr_valid,
    output lc3b_pkg::lc3b_reg  src1,
    output lc3b_pkg::lc3b_reg  src2,
    output lc3b_pkg::lc3b_reg  dest
);

    import lc3b_pkg::*;

    lc3b_word pc_next;
    logic     pc_load;
    logic     ir_load;
    logic     ir_stall;

    pc_select u_pc_select (
        .resp_a      (resp_a),
        .stall       (stall),
        .br_en       (br_en),
        .trap_en     (trap_en),
        .jmp_jsr_en  (jmp_jsr_en),
        .b11         (b11),
        .pc_out      (pc_out),
        .pc_br_in    (pc_br_in),
        .sr1_data_in (sr1_data_in),
        .trap_mem    (trap_mem),
        .pc_load     (pc_load),
        .pc_next     (pc_next)
    );

    // ==============================
    // PC and memory request
    // ==============================

    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            pc_out <= PC_RESET;
        end else if (pc_load) begin
            pc_out <= pc_next;
        end
    end

    assign read_a    = 1'b1;   // Fetch always wants the word at the PC
    assign address_a = pc_out;

    // ==============================
    // Instruction register
    // ==============================

    // Capture only a response that the PC also steps past
    assign ir_load = pc_load && resp_a && !stall && !flush;

    instr_reg u_instr_reg (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .load                 (ir_load),
        .resp                 (resp_a),
        .flush                (flush),
        .in                   (rdata_a),
        .instruction          (instruction),
        .instr_valid          (instr_valid),
        .ir_stall             (ir_stall),
        .dest                 (dest),
        .src1                 (src1),
        .src2                 (src2)
    );

    // Counts every edge with no valid instruction and wraps at 16 bits
    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            if_stall_count <= '0;
        end else if (ir_stall) begin
            if_stall_count <= if_stall_count + 16'd1;
        end
    end

    a_count_holds : assert property (
        @(posedge clk) disable iff (if_stall_count_reset)
        !ir_stall |=> $stable(if_stall_count)
    ) else $error("Stall counter moved while the IR held a valid instruction");

endmodule : if_datapath

// ==== logic/instr_reg.sv ====
`timescale 1ns/1ps

module instr_reg (
    input  logic              clk,
    input  logic              if_stall_count_reset,
    input  logic              load,
    input  logic              resp,
    input  logic              flush,
    input  lc3b_pkg::lc3b_word in,
    output lc3b_pkg::lc3b_word instruction,
    output logic              instr_valid,
    output logic              ir_stall,
    output lc3b_pkg::lc3b_reg  dest,
    output lc3b_pkg::lc3b_reg  src1,
    output lc3b_pkg::lc3b_reg  src2
);

    // ==============================
    // Word and valid bit
    // ==============================

    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            instruction <= '0;
            instr_valid <= 1'b0;
        end else if (load) begin
            instruction <= in;
            instr_valid <= 1'b1;
        end else if (flush || resp) begin
            instr_valid <= 1'b0;  // Flushed or the response was not taken
        end
    end

    // No valid instruction means the stage is stalling
    assign ir_stall = !instr_valid;

    // ==============================
    // Register fields
    // ==============================

    assign dest = instruction[11:9];
    assign src1 = instruction[8:6];
    assign src2 = instruction[2:0];  // Only meaningful in register mode

    // A flush that is not overridden by a load must empty the register
    a_flush_clears_valid : assert property (
        @(posedge clk) disable iff (if_stall_count_reset)
        (flush && !load) |=> !instr_valid
    ) else $error("instr_valid still high after a flush");

endmodule : instr_reg

// ==== logic/pc_select.sv ====
`timescale 1ns/1ps

module pc_select (
    input  logic              resp_a,
    input  logic              stall,
    input  logic              br_en,
    input  logic              trap_en,
    input  logic              jmp_jsr_en,
    input  logic              b11,
    input  lc3b_pkg::lc3b_word pc_out,
    input  lc3b_pkg::lc3b_word pc_br_in,
    input  lc3b_pkg::lc3b_word sr1_data_in,
    input  lc3b_pkg::lc3b_word trap_mem,
    output logic              pc_load,
    output lc3b_pkg::lc3b_word pc_next
);

    import lc3b_pkg::*;

    pc_src_e  pc_src;
    lc3b_word pc_plus2;

    assign pc_plus2 = pc_out + PC_STEP;

    // ==============================
    // Source priority
    // ==============================

    always_comb begin
        if (br_en) begin
            pc_src = pc_src_branch;
        end else if (trap_en) begin
            pc_src = pc_src_trap;
        end else if (jmp_jsr_en && b11) begin
            pc_src = pc_src_branch;  // JSR takes the PC-relative target
        end else if (jmp_jsr_en) begin
            pc_src = pc_src_reg;     // JMP, RET and JSRR jump through a register
        end else begin
            pc_src = pc_src_plus2;
        end
    end

    always_comb begin
        case (pc_src)
            pc_src_branch: pc_next = pc_br_in;
            pc_src_reg:    pc_next = sr1_data_in;
            pc_src_trap:   pc_next = trap_mem;
            default:       pc_next = pc_plus2;
        endcase
    end

    // A redirect wins over stall. Otherwise the PC steps only on a response
    assign pc_load = (pc_src != pc_src_plus2) || (resp_a && !stall);

endmodule : pc_select

// ==== logic/lc3b_pkg.sv ====
package lc3b_pkg;

    // ==============================
    // Data types
    // ==============================

    typedef logic [15:0] lc3b_word;  // Data word or byte address
    typedef logic [2:0]  lc3b_reg;   // Register file index

    // Where the next PC comes from
    typedef enum logic [1:0] {
        pc_src_plus2  = 2'b00,
        pc_src_branch = 2'b01,  // PC-relative target, also used by JSR
        pc_src_reg    = 2'b10,  // Base register for JMP and JSRR
        pc_src_trap   = 2'b11   // Vector word read from the trap table
    } pc_src_e;

    // ==============================
    // Fetch constants
    // ==============================

    localparam lc3b_word PC_RESET = 16'h0000;  // First instruction address
    localparam lc3b_word PC_STEP  = 16'd2;     // Instructions are two bytes wide

    // ==============================
    // Instruction memory
    // ==============================

    localparam int DEFAULT_MEM_WORDS   = 256;
    localparam int DEFAULT_MEM_LATENCY = 2;
    localparam int MAX_MEM_LATENCY     = 7;

    // Wide enough to count up to the largest latency
    localparam int WAIT_BITS = $clog2(MAX_MEM_LATENCY + 1);

endpackage : lc3b_pkg
